// File: verilog/soc_macros.svh
/*
 * SoC peripheral subsystem constants
 * Bus widths, slot map geometry, GPIO counts and device ids
 */
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

`define SOC_ARCH_W       32
`define SOC_WADDR_W      30
`define SOC_SLOT_W       2
`define SOC_SLOT_OFS_W   10
`define SOC_SLOT_MAPSZ   4096
`define SOC_GP0_COUNT    16
`define SOC_GP1_COUNT    5
`define SOC_RST_CNT_W    4
`define SOC_ID           2
`define SOC_DEVID_DEVTBL 7
`define SOC_DEVID_GPIO   6
`define SOC_DEVID_NONE   0

`endif

// File: verilog/soc_pkg.sv
/*
 * SoC peripheral bus types
 * Data and address words, bus operations, slot numbering, device table entries
 */
`include "soc_macros.svh"

package soc_pkg;

	typedef logic [`SOC_ARCH_W-1:0]     word_t;
	typedef logic [`SOC_WADDR_W-1:0]    waddr_t;
	typedef logic [`SOC_ARCH_W/8-1:0]   sel_t;

	// Encoding follows the peripheral bus op field
	typedef enum logic [1:0] {
		BUS_NONE  = 2'd0,
		BUS_WRITE = 2'd1,
		BUS_READ  = 2'd2
	} bus_op_t;

	typedef enum logic [`SOC_SLOT_W-1:0] {
		SLOT_DEVTBL  = 2'd0,
		SLOT_GPIO0   = 2'd1,
		SLOT_GPIO1   = 2'd2,
		SLOT_INVALID = 2'd3
	} slot_t;

	typedef struct packed {
		logic [4:0] id;
		word_t      mapsz;
		logic       use_irq;
	} dev_entry_t;

endpackage

// File: verilog/periph_bus_if.sv
/*
 * One peripheral bus slot
 * Request from the decoder and combinational read data from the device
 */
`timescale 1ns/1ps
`include "soc_macros.svh"

interface periph_bus_if import soc_pkg::*; ();

	bus_op_t                   op;
	logic [`SOC_SLOT_OFS_W-1:0] off;
	word_t                     wdata;
	sel_t                      sel;
	word_t                     rdata;

	modport master (output op, output off, output wdata, output sel, input rdata);
	modport slave  (input op, input off, input wdata, input sel, output rdata);

endinterface

// File: verilog/reset_seq.sv
/*
 * Bus reset sequencer
 * Stretches the board reset, restarts it on software cold or warm reset
 * and latches a software power-off until the next board reset
 */
`timescale 1ns/1ps
`include "soc_macros.svh"

module reset_seq (
	input  logic       clk_2x_w,
	input  logic       rst_p,
	input  logic [1:0] sw_rst_req_i,
	output logic       bus_rst_o,
	output logic       bus_rdy_o,
	output logic       powered_off_o
);

	logic [`SOC_RST_CNT_W-1:0] rst_cnt;
	logic                      pwr_off_q;
	logic                      cold_rst;
	logic                      warm_rst;
	logic                      pwr_off;

	assign cold_rst = sw_rst_req_i[1] & sw_rst_req_i[0];
	assign warm_rst = sw_rst_req_i[1] & ~sw_rst_req_i[0];
	assign pwr_off  = ~sw_rst_req_i[1] & sw_rst_req_i[0];

	// No global reset primitive here, so cold behaves like warm
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			rst_cnt <= '1;
		end else if (cold_rst || warm_rst) begin
			rst_cnt <= '1;
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwr_off_q <= 1'b0;
		end else if (pwr_off) begin
			pwr_off_q <= 1'b1;
		end
	end

	assign bus_rst_o     = (rst_cnt != '0) | pwr_off_q;
	assign bus_rdy_o     = ~bus_rst_o;
	assign powered_off_o = pwr_off_q;

endmodule

// File: verilog/bus_decoder.sv
/*
 * Peripheral bus decoder
 * Routes each request to one slot and registers the read data,
 * unmapped addresses read zero and drop writes
 */
`timescale 1ns/1ps
`include "soc_macros.svh"

module bus_decoder import soc_pkg::*; (
	input  logic    clk_2x_w,
	input  logic    rst_p,
	input  logic    bus_rst_i,
	input  bus_op_t bus_op_i,
	input  waddr_t  bus_addr_i,
	input  word_t   bus_wdata_i,
	input  sel_t    bus_sel_i,
	output word_t   bus_rdata_o,
	periph_bus_if.master devtbl_bus,
	periph_bus_if.master gpio0_bus,
	periph_bus_if.master gpio1_bus
);

	localparam int SLOT_LSB = `SOC_SLOT_OFS_W;
	localparam int UPPER_LSB = `SOC_SLOT_OFS_W + `SOC_SLOT_W;

	logic                       upper_zero;
	slot_t                      slot;
	bus_op_t                    req_op;
	logic [`SOC_SLOT_OFS_W-1:0] req_off;
	word_t                      rd_mux;
	word_t                      rdata_q;

	// Anything above the slot bits falls into the invalid device
	assign upper_zero = (bus_addr_i[`SOC_WADDR_W-1:UPPER_LSB] == '0);
	assign slot       = upper_zero ? slot_t'(bus_addr_i[SLOT_LSB +: `SOC_SLOT_W]) : SLOT_INVALID;
	assign req_op     = bus_rst_i ? BUS_NONE : bus_op_i;
	assign req_off    = bus_addr_i[`SOC_SLOT_OFS_W-1:0];

	assign devtbl_bus.op    = (slot == SLOT_DEVTBL) ? req_op : BUS_NONE;
	assign devtbl_bus.off   = req_off;
	assign devtbl_bus.wdata = bus_wdata_i;
	assign devtbl_bus.sel   = bus_sel_i;

	assign gpio0_bus.op    = (slot == SLOT_GPIO0) ? req_op : BUS_NONE;
	assign gpio0_bus.off   = req_off;
	assign gpio0_bus.wdata = bus_wdata_i;
	assign gpio0_bus.sel   = bus_sel_i;

	assign gpio1_bus.op    = (slot == SLOT_GPIO1) ? req_op : BUS_NONE;
	assign gpio1_bus.off   = req_off;
	assign gpio1_bus.wdata = bus_wdata_i;
	assign gpio1_bus.sel   = bus_sel_i;

	always_comb begin
		case (slot)
			SLOT_DEVTBL: rd_mux = devtbl_bus.rdata;
			SLOT_GPIO0:  rd_mux = gpio0_bus.rdata;
			SLOT_GPIO1:  rd_mux = gpio1_bus.rdata;
			default:     rd_mux = '0;
		endcase
	end

	// Holds the last read until another one completes
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			rdata_q <= '0;
		end else if (req_op == BUS_READ) begin
			rdata_q <= rd_mux;
		end
	end

	assign bus_rdata_o = rdata_q;

endmodule

// File: verilog/dev_table.sv
/*
 * Device table
 * Read-only description of every bus slot and the software reset register
 */
`timescale 1ns/1ps
`include "soc_macros.svh"

module dev_table import soc_pkg::*; (
	input  logic       clk_2x_w,
	input  logic       bus_rst_i,
	periph_bus_if.slave bus,
	output logic [1:0] sw_rst_req_o
);

	// Two words per slot after the id word and a spare word
	localparam int TBL_END = 2 + 2 * (1 << `SOC_SLOT_W);

	logic [`SOC_SLOT_OFS_W-1:0] tbl_ofs;
	dev_entry_t                 entry;
	logic [1:0]                 rst_req_q;

	function automatic dev_entry_t slot_entry(input slot_t s);
		dev_entry_t e;
		e.mapsz = word_t'(`SOC_SLOT_MAPSZ);
		case (s)
			SLOT_DEVTBL: begin
				e.id      = 5'(`SOC_DEVID_DEVTBL);
				e.use_irq = 1'b0;
			end
			SLOT_GPIO0, SLOT_GPIO1: begin
				e.id      = 5'(`SOC_DEVID_GPIO);
				e.use_irq = 1'b1;
			end
			default: begin
				e.id      = 5'(`SOC_DEVID_NONE);
				e.use_irq = 1'b0;
			end
		endcase
		return e;
	endfunction

	assign tbl_ofs = bus.off - `SOC_SLOT_OFS_W'(2);
	assign entry   = slot_entry(slot_t'(tbl_ofs[`SOC_SLOT_W:1]));

	always_comb begin
		bus.rdata = '0;
		if (bus.off == '0) begin
			bus.rdata = word_t'(`SOC_ID);
		end else if (bus.off >= 2 && bus.off < TBL_END) begin
			if (tbl_ofs[0])
				bus.rdata = entry.mapsz;
			else
				bus.rdata = {entry.use_irq, {(`SOC_ARCH_W-6){1'b0}}, entry.id};
		end
	end

	// Request bits drop once the bus enters reset
	always_ff @(posedge clk_2x_w) begin
		if (bus_rst_i) begin
			rst_req_q <= 2'b00;
		end else if (bus.op == BUS_WRITE && bus.off == '0 && bus.sel[0]) begin
			rst_req_q <= bus.wdata[1:0];
		end
	end

	assign sw_rst_req_o = rst_req_q;

endmodule

// File: verilog/gpio_port.sv
/*
 * GPIO port
 * Samples inputs, drives a byte-writable output register
 * and flags an interrupt when the sampled inputs change
 */
`timescale 1ns/1ps

module gpio_port import soc_pkg::*; #(
	parameter int IOCOUNT = 8
) (
	input  logic               clk_2x_w,
	input  logic               bus_rst_i,
	periph_bus_if.slave        bus,
	input  logic [IOCOUNT-1:0] io_i,
	output logic [IOCOUNT-1:0] io_o,
	output logic               irq_o
);

	logic [IOCOUNT-1:0] in_q;
	logic [IOCOUNT-1:0] in_prev;
	logic [IOCOUNT-1:0] out_q;
	logic               pending;
	logic               changed;
	word_t              wmask;

	always_ff @(posedge clk_2x_w) begin
		in_q    <= io_i;
		in_prev <= in_q;
	end

	assign changed = (in_q != in_prev);
	assign wmask   = {{8{bus.sel[3]}}, {8{bus.sel[2]}}, {8{bus.sel[1]}}, {8{bus.sel[0]}}};

	always_ff @(posedge clk_2x_w) begin
		if (bus_rst_i) begin
			out_q <= '0;
		end else if (bus.op == BUS_WRITE && bus.off == 1) begin
			out_q <= (out_q & ~wmask[IOCOUNT-1:0]) | (bus.wdata[IOCOUNT-1:0] & wmask[IOCOUNT-1:0]);
		end
	end

	// A change in the same cycle as the clear keeps the flag set
	always_ff @(posedge clk_2x_w) begin
		if (bus_rst_i) begin
			pending <= 1'b0;
		end else if (bus.op == BUS_WRITE && bus.off == 2) begin
			pending <= changed;
		end else if (changed) begin
			pending <= 1'b1;
		end
	end

	always_comb begin
		case (bus.off)
			0:       bus.rdata = word_t'(in_q);
			1:       bus.rdata = word_t'(out_q);
			2:       bus.rdata = word_t'(pending);
			default: bus.rdata = '0;
		endcase
	end

	assign io_o  = out_q;
	assign irq_o = pending;

endmodule

// File: verilog/soc_top.sv
/*
 * SoC peripheral subsystem top
 * Reset sequencer, bus decoder, device table and two GPIO ports
 */
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_top import soc_pkg::*; (
	input  logic                      clk_2x_w,
	input  logic                      rst_p,
	input  bus_op_t                   bus_op_i,
	input  waddr_t                    bus_addr_i,
	input  word_t                     bus_wdata_i,
	input  sel_t                      bus_sel_i,
	output word_t                     bus_rdata_o,
	output logic                      bus_rdy_o,
	input  logic [`SOC_GP0_COUNT-1:0] gp0_i,
	output logic [`SOC_GP0_COUNT-1:0] gp0_o,
	input  logic [`SOC_GP1_COUNT-1:0] gp1_i,
	output logic [1:0]                irq_o,
	output logic                      powered_off_o
);

	logic       bus_rst_w;
	logic [1:0] sw_rst_req_w;

	periph_bus_if devtbl_bus ();
	periph_bus_if gpio0_bus ();
	periph_bus_if gpio1_bus ();

	reset_seq rst_seq (
		.clk_2x_w      (clk_2x_w),
		.rst_p         (rst_p),
		.sw_rst_req_i  (sw_rst_req_w),
		.bus_rst_o     (bus_rst_w),
		.bus_rdy_o     (bus_rdy_o),
		.powered_off_o (powered_off_o)
	);

	bus_decoder decoder (
		.clk_2x_w    (clk_2x_w),
		.rst_p       (rst_p),
		.bus_rst_i   (bus_rst_w),
		.bus_op_i    (bus_op_i),
		.bus_addr_i  (bus_addr_i),
		.bus_wdata_i (bus_wdata_i),
		.bus_sel_i   (bus_sel_i),
		.bus_rdata_o (bus_rdata_o),
		.devtbl_bus  (devtbl_bus.master),
		.gpio0_bus   (gpio0_bus.master),
		.gpio1_bus   (gpio1_bus.master)
	);

	dev_table devtbl (
		.clk_2x_w     (clk_2x_w),
		.bus_rst_i    (bus_rst_w),
		.bus          (devtbl_bus.slave),
		.sw_rst_req_o (sw_rst_req_w)
	);

	gpio_port #(.IOCOUNT(`SOC_GP0_COUNT)) gpio_switches_leds (
		.clk_2x_w  (clk_2x_w),
		.bus_rst_i (bus_rst_w),
		.bus       (gpio0_bus.slave),
		.io_i      (gp0_i),
		.io_o      (gp0_o),
		.irq_o     (irq_o[0])
	);

	// Buttons have no outputs on the board
	gpio_port #(.IOCOUNT(`SOC_GP1_COUNT)) gpio_buttons (
		.clk_2x_w  (clk_2x_w),
		.bus_rst_i (bus_rst_w),
		.bus       (gpio1_bus.slave),
		.io_i      (gp1_i),
		.io_o      (),
		.irq_o     (irq_o[1])
	);

endmodule

// File: tb/tb_soc.sv
/*
 * Testbench for the SoC peripheral subsystem
 * Replays bus cases from a data file, then random switch changes
 */
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc import soc_pkg::*; ();

	localparam int     TIMEOUT    = 100;
	localparam int     MAX_CASES  = 128;
	localparam int     CASE_W     = 7;
	localparam waddr_t GPIO0_IN   = waddr_t'(1 << `SOC_SLOT_OFS_W);
	localparam waddr_t GPIO0_PEND = waddr_t'((1 << `SOC_SLOT_OFS_W) + 2);

	logic                      clk_2x_w = 1'b0;
	logic                      rst_p;
	bus_op_t                   bus_op_i;
	waddr_t                    bus_addr_i;
	word_t                     bus_wdata_i;
	sel_t                      bus_sel_i;
	word_t                     bus_rdata_o;
	logic                      bus_rdy_o;
	logic [`SOC_GP0_COUNT-1:0] gp0_i;
	logic [`SOC_GP0_COUNT-1:0] gp0_o;
	logic [`SOC_GP1_COUNT-1:0] gp1_i;
	logic [1:0]                irq_o;
	logic                      powered_off_o;

	// Seven words per case: kind, addr, wdata, sel, gp0, gp1, expected
	word_t case_mem [0:MAX_CASES*CASE_W-1];
	int    err_count = 0;
	int    test_count = 0;
	int    test_fail = 0;

	soc_top dut (
		.clk_2x_w      (clk_2x_w),
		.rst_p         (rst_p),
		.bus_op_i      (bus_op_i),
		.bus_addr_i    (bus_addr_i),
		.bus_wdata_i   (bus_wdata_i),
		.bus_sel_i     (bus_sel_i),
		.bus_rdata_o   (bus_rdata_o),
		.bus_rdy_o     (bus_rdy_o),
		.gp0_i         (gp0_i),
		.gp0_o         (gp0_o),
		.gp1_i         (gp1_i),
		.irq_o         (irq_o),
		.powered_off_o (powered_off_o)
	);

	always #5 clk_2x_w = ~clk_2x_w;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			err_count++;
			$display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bits(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			err_count++;
			$display("FAIL at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_gpio(input string name, input logic [`SOC_GP0_COUNT-1:0] exp,
			input logic [`SOC_GP0_COUNT-1:0] act);
		if (act !== exp) begin
			err_count++;
			$display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic wait_rdy(input logic level);
		int n;
		n = 0;
		while (bus_rdy_o !== level && n < TIMEOUT) begin
			@(negedge clk_2x_w);
			n++;
		end
		if (bus_rdy_o !== level) begin
			err_count++;
			$display("Timeout at %0t: bus_rdy_o never went to %0b", $time, level);
		end
	endtask

	task automatic wait_irq(input logic [1:0] level);
		int n;
		n = 0;
		while (irq_o !== level && n < TIMEOUT) begin
			@(negedge clk_2x_w);
			n++;
		end
		if (irq_o !== level) begin
			err_count++;
			$display("Timeout at %0t: irq_o never went to %b", $time, level);
		end
	endtask

	// Bus tasks start and end on a falling edge
	task automatic bus_write(input waddr_t addr, input word_t data, input sel_t sel);
		wait_rdy(1'b1);
		bus_op_i    = BUS_WRITE;
		bus_addr_i  = addr;
		bus_wdata_i = data;
		bus_sel_i   = sel;
		@(negedge clk_2x_w);
		bus_op_i = BUS_NONE;
	endtask

	task automatic bus_read(input waddr_t addr, input word_t exp);
		wait_rdy(1'b1);
		bus_op_i   = BUS_READ;
		bus_addr_i = addr;
		@(negedge clk_2x_w);
		bus_op_i = BUS_NONE;
		check_word($sformatf("bus_rdata_o for %h", addr), exp, bus_rdata_o);
	endtask

	task automatic pulse_reset();
		rst_p = 1'b1;
		repeat (4) @(negedge clk_2x_w);
		rst_p = 1'b0;
	endtask

	task automatic report_test(input string label, input int errs_before);
		test_count++;
		if (err_count != errs_before) begin
			test_fail++;
			$display("test %0d %s: failed", test_count, label);
		end else begin
			$display("test %0d %s: ok", test_count, label);
		end
	endtask

	task automatic run_case(input int num);
		word_t  kind;
		waddr_t addr;
		word_t  wdata;
		sel_t   sel;
		word_t  expv;
		int     errs_before;
		errs_before = err_count;
		kind  = case_mem[num*CASE_W];
		addr  = case_mem[num*CASE_W+1][`SOC_WADDR_W-1:0];
		wdata = case_mem[num*CASE_W+2];
		sel   = case_mem[num*CASE_W+3][3:0];
		gp0_i = case_mem[num*CASE_W+4][`SOC_GP0_COUNT-1:0];
		gp1_i = case_mem[num*CASE_W+5][`SOC_GP1_COUNT-1:0];
		expv  = case_mem[num*CASE_W+6];
		case (kind)
			32'h0: repeat (wdata) @(negedge clk_2x_w);
			32'h1: bus_write(addr, wdata, sel);
			32'h2: bus_read(addr, expv);
			32'h3: check_gpio("gp0_o", expv[`SOC_GP0_COUNT-1:0], gp0_o);
			32'h4: wait_irq(expv[1:0]);
			32'h5: wait_rdy(expv[0]);
			32'h6: check_bits("bus_rdy_o and powered_off_o", expv[1:0], {bus_rdy_o, powered_off_o});
			32'h7: pulse_reset();
			default: begin
				err_count++;
				$display("Case %0d has an unknown kind %h", num + 1, kind);
			end
		endcase
		report_test($sformatf("case %0d kind %0h addr %h", num + 1, kind, addr), errs_before);
	endtask

	initial begin
		int                        idx;
		int                        i;
		int                        errs_before;
		logic [31:0]               seed;
		logic [`SOC_GP0_COUNT-1:0] next_gp0;
		rst_p       = 1'b1;
		bus_op_i    = BUS_NONE;
		bus_addr_i  = '0;
		bus_wdata_i = '0;
		bus_sel_i   = '0;
		gp0_i       = '0;
		gp1_i       = '0;
		$readmemh("tb/soc_cases.txt", case_mem);
		repeat (4) @(negedge clk_2x_w);
		rst_p = 1'b0;

		errs_before = err_count;
		wait_rdy(1'b1);
		check_bits("irq_o", 2'b00, irq_o);
		check_gpio("gp0_o", '0, gp0_o);
		check_bits("powered_off_o", 2'b00, {1'b0, powered_off_o});
		report_test("reset state", errs_before);

		idx = 0;
		while (idx < MAX_CASES && case_mem[idx*CASE_W] !== 32'hf) begin
			run_case(idx);
			idx++;
		end
		if (idx == 0 || idx == MAX_CASES) begin
			err_count++;
			$display("Case file tb/soc_cases.txt is missing, empty or has no end marker");
		end

		// Random switch patterns, each one a fresh change interrupt
		seed = 32'hc9e80299;
		for (i = 0; i < 6; i++) begin
			errs_before = err_count;
			seed = xorshift32(seed);
			next_gp0 = seed[`SOC_GP0_COUNT-1:0];
			if (next_gp0 == gp0_i)
				next_gp0 = ~next_gp0;
			gp0_i = next_gp0;
			wait_irq(2'b01);
			bus_write(GPIO0_PEND, '0, 4'hf);
			bus_read(GPIO0_PEND, '0);
			bus_read(GPIO0_IN, {16'h0000, next_gp0});
			wait_irq(2'b00);
			report_test($sformatf("random switch change to %h", next_gp0), errs_before);
		end

		$display("Tests run: %0d, tests failed: %0d, errors: %0d", test_count, test_fail, err_count);
		if (err_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: tb/soc_cases.txt
// kind addr wdata sel gp0 gp1 expected, all hex
// kind 0 idle wdata cycles, 1 write, 2 read, 3 gp0_o, 4 wait irq_o,
// 5 wait bus_rdy_o, 6 {bus_rdy_o, powered_off_o}, 7 rst_p pulse, f end
2 00000000 00000000 0 0000 00 00000002
2 00000002 00000000 0 0000 00 00000007
2 00000003 00000000 0 0000 00 00001000
2 00000004 00000000 0 0000 00 80000006
2 00000005 00000000 0 0000 00 00001000
2 00000006 00000000 0 0000 00 80000006
2 00000007 00000000 0 0000 00 00001000
2 00000008 00000000 0 0000 00 00000000
2 00000009 00000000 0 0000 00 00001000
2 0000000a 00000000 0 0000 00 00000000
// GPIO0 outputs, byte lanes
1 00000401 0000a5c3 f 0000 00 00000000
2 00000401 00000000 0 0000 00 0000a5c3
1 00000401 12345678 2 0000 00 00000000
2 00000401 00000000 0 0000 00 000056c3
1 00000401 ffff00ee 1 0000 00 00000000
3 00000000 00000000 0 0000 00 000056ee
// Button interrupt, then switch interrupt
4 00000000 00000000 0 0000 15 00000002
2 00000800 00000000 0 0000 15 00000015
1 00000802 00000000 f 0000 15 00000000
2 00000802 00000000 0 0000 15 00000000
4 00000000 00000000 0 0001 15 00000001
2 00000402 00000000 0 0001 15 00000001
1 00000402 00000000 f 0001 15 00000000
2 00000402 00000000 0 0001 15 00000000
4 00000000 00000000 0 0001 15 00000000
2 00000400 00000000 0 0001 15 00000001
// Invalid slot and unused upper address bits
2 00000c00 00000000 0 0001 15 00000000
1 00000c01 ffffffff f 0001 15 00000000
2 00000c01 00000000 0 0001 15 00000000
1 00001401 00000000 f 0001 15 00000000
2 00001401 00000000 0 0001 15 00000000
3 00000000 00000000 0 0001 15 000056ee
// Warm reset, then power-off until rst_p
1 00000000 00000002 1 0001 15 00000000
5 00000000 00000000 0 0001 15 00000000
5 00000000 00000000 0 0001 15 00000001
6 00000000 00000000 0 0001 15 00000002
3 00000000 00000000 0 0001 15 00000000
1 00000000 00000001 1 0001 15 00000000
5 00000000 00000000 0 0001 15 00000000
0 00000000 00000014 0 0001 15 00000000
6 00000000 00000000 0 0001 15 00000001
7 00000000 00000000 0 0001 15 00000000
5 00000000 00000000 0 0001 15 00000001
6 00000000 00000000 0 0001 15 00000002
f 00000000 00000000 0 0000 00 00000000

// File: files.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/periph_bus_if.sv
verilog/reset_seq.sv
verilog/bus_decoder.sv
verilog/dev_table.sv
verilog/gpio_port.sv
verilog/soc_top.sv
tb/tb_soc.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_soc -f files.f -o tb_soc_sim
./obj_dir/tb_soc_sim > sim.log
cat sim.log

if grep -qx "Done: no errors" sim.log; then
	exit 0
fi
exit 1
